// File: verilog.f
loader_pkg.sv
loader_if.sv
load_decoder.sv
image_mapper.sv
prg_loader.sv
reg_injector.sv
write_router.sv
vic20_loader.sv
vic20_loader_sva.sv
tb_clock.sv
tb_vic20_loader.sv

// File: Makefile
# Verilator flow for the VIC-20 image loader

VERILATOR ?= verilator
TOP       ?= tb_vic20_loader
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_vic20_loader.sv
/*
 * VIC-20 image loader testbench
 * Drives ROM, PRG, TAP and unknown downloads, predicts each memory
 * write from the loader rules and checks the write stream in order.
 */
`timescale 1ns/1ps

module tb_vic20_loader;
    import loader_pkg::*;

    // Download sizes in bytes
    localparam int ROM_BYTES     = 'hC100;
    localparam int PRG_BYTES     = 4200;
    localparam int CRT_BYTES     = 8208;
    localparam int TAP_BYTES     = 300;
    localparam int NONE_BYTES    = 64;
    localparam int TEST_OVERHEAD = 200;
    localparam int DRAIN_CYCLES  = 100;
    // Two cycles per byte, doubled for margin
    localparam int WATCHDOG_CYCLES = 2 * (6 * TEST_OVERHEAD +
        2 * (ROM_BYTES + PRG_BYTES + 2 + CRT_BYTES + TAP_BYTES + NONE_BYTES));

    logic                  clk_sys;
    logic                  reset;
    logic                  dl_active_i;
    logic [7:0]            dl_index_i;
    logic                  dl_wr_i;
    logic [DL_ADDR_W-1:0]  dl_addr_i;
    logic [7:0]            dl_data_i;
    logic                  crt_no_header_i;
    logic                  ext_we_o;
    logic [EXT_ADDR_W-1:0] ext_addr_o;
    logic [7:0]            ext_data_o;
    logic                  int_we_o;
    logic [CPU_ADDR_W-1:0] int_addr_o;
    logic [7:0]            int_data_o;
    logic                  force_reset_o;
    logic [EXT_ADDR_W-1:0] tap_end_addr_o;

    // Expected writes packed as internal flag, address, data
    logic [31:0]           exp_q [$];
    logic [31:0]           got_word;
    logic [31:0]           exp_word;
    logic [7:0]            byte_val;
    logic [CPU_ADDR_W-1:0] prg_end;
    string                 cur_test;
    int                    err_cnt = 0;
    int                    test_err_base = 0;
    int                    force_cnt = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;

    tb_clock i_tb_clock (
        .clk_sys_o (clk_sys),
        .reset_o   (reset)
    );

    vic20_loader i_vic20_loader (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl_active_i     (dl_active_i),
        .dl_index_i      (dl_index_i),
        .dl_wr_i         (dl_wr_i),
        .dl_addr_i       (dl_addr_i),
        .dl_data_i       (dl_data_i),
        .crt_no_header_i (crt_no_header_i),
        .ext_we_o        (ext_we_o),
        .ext_addr_o      (ext_addr_o),
        .ext_data_o      (ext_data_o),
        .int_we_o        (int_we_o),
        .int_addr_o      (int_addr_o),
        .int_data_o      (int_data_o),
        .force_reset_o   (force_reset_o),
        .tap_end_addr_o  (tap_end_addr_o)
    );

    // ==============================
    // Reference model
    // ==============================
    function automatic void expect_write(input logic internal,
                                         input logic [EXT_ADDR_W-1:0] addr,
                                         input logic [7:0] data);
        exp_q.push_back({internal, addr, data});
    endfunction

    function automatic void rom_expect(input int off, input logic [7:0] data);
        logic [EXT_ADDR_W-1:0] low13;
        low13 = EXT_ADDR_W'(off & 'h1FFF);
        case ((off >> 13) & 7)
            2: expect_write(1'b0, 23'h00E000 + low13, data);
            3: expect_write(1'b0, (23'h00E000 | (23'h1 << NTSC_KERNAL_BIT)) + low13, data);
            4: expect_write(1'b0, 23'h00C000 + low13, data);
            5: expect_write(1'b1, 23'h008000 + EXT_ADDR_W'(off & 'hFFF), data);
            default: ;
        endcase
    endfunction

    function automatic logic prg_internal(input logic [15:0] a);
        return (a < 16'h0400) ||
               (a >= 16'h1000 && a < 16'h2000) ||
               (a >= 16'h9400 && a < 16'h9800);
    endfunction

    // Low byte to even table slots, high byte to odd ones
    function automatic void pointer_expect(input logic [15:0] end_addr);
        for (int i = 0; i < PTR_COUNT; i++)
            expect_write(1'b1, EXT_ADDR_W'(PTR_ADDRS[i]),
                         (i % 2 == 1) ? end_addr[15:8] : end_addr[7:0]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v == exp_v) else begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // Each port write is matched against the oldest expected write
    always @(negedge clk_sys) begin
        if (force_reset_o)
            force_cnt++;
        if (ext_we_o || int_we_o) begin
            if (int_we_o)
                got_word = {1'b1, 7'd0, int_addr_o, int_data_o};
            else
                got_word = {1'b0, ext_addr_o, ext_data_o};
            assert (exp_q.size() > 0) else begin
                $display("%s: write %h arrived with no write pending", cur_test, got_word);
                err_cnt++;
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                check_value("write", exp_word, got_word);
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic start_download(input logic [7:0] index);
        @(negedge clk_sys);
        dl_index_i  = index;
        dl_active_i = 1'b1;
    endtask

    task automatic send_byte(input int offset, input logic [7:0] data);
        @(negedge clk_sys);
        dl_wr_i   = 1'b1;
        dl_addr_i = DL_ADDR_W'(offset);
        dl_data_i = data;
        @(negedge clk_sys);
        dl_wr_i   = 1'b0;
    endtask

    task automatic stop_download();
        @(negedge clk_sys);
        dl_active_i = 1'b0;
    endtask

    // Payload bytes to consecutive addresses, saturating at the limit
    task automatic prg_payload(input logic [15:0] start, input int first_off,
                               input int count, output logic [15:0] end_addr);
        logic [15:0] a;
        a = start;
        for (int k = 0; k < count; k++) begin
            byte_val = 8'($urandom);
            expect_write(prg_internal(a), EXT_ADDR_W'(a), byte_val);
            send_byte(first_off + k, byte_val);
            if (a != PRG_LIMIT)
                a = a + 16'd1;
        end
        end_addr = a;
    endtask

    task automatic begin_test(input string name);
        cur_test      = name;
        test_err_base = err_cnt;
        force_cnt     = 0;
    endtask

    task automatic finish_test(input int exp_force);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk_sys);
            waited++;
        end
        // Room for a reset pulse after the last pointer write
        repeat (10) @(negedge clk_sys);
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected writes never arrived", cur_test, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
        check_value("force_reset pulses", 32'(exp_force), 32'(force_cnt));
        tests_run++;
        if (err_cnt != test_err_base)
            tests_failed++;
        $display("test %-10s %s, %0d errors", cur_test,
                 (err_cnt == test_err_base) ? "ok" : "FAILED", err_cnt - test_err_base);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("Watchdog expired in test %s", cur_test);
        $display("Test failed");
        $finish;
    end

    initial begin
        dl_active_i     = 1'b0;
        dl_index_i      = 8'h00;
        dl_wr_i         = 1'b0;
        dl_addr_i       = '0;
        dl_data_i       = 8'h00;
        crt_no_header_i = 1'b0;
        cur_test        = "startup";
        void'($urandom(75339));
        @(negedge reset);

        begin_test("reset");
        repeat (20) @(negedge clk_sys);
        check_value("tap_end_addr", 32'(TAP_MEM_START), 32'(tap_end_addr_o));
        finish_test(0);

        begin_test("rom");
        start_download(8'h00);
        for (int off = 0; off < ROM_BYTES; off++) begin
            byte_val = 8'($urandom);
            rom_expect(off, byte_val);
            send_byte(off, byte_val);
        end
        stop_download();
        finish_test(0);

        // Header selects $1001, payload crosses into external RAM
        begin_test("prg_header");
        start_download(8'h01);
        send_byte(0, 8'h01);
        send_byte(1, 8'h10);
        prg_payload(16'h1001, 2, PRG_BYTES, prg_end);
        stop_download();
        pointer_expect(prg_end);
        finish_test(0);

        begin_test("prg_cart");
        crt_no_header_i = 1'b1;
        start_download(8'h41);
        prg_payload(PRG_CART_ADDR, 0, CRT_BYTES, prg_end);
        stop_download();
        pointer_expect(prg_end);
        finish_test(1);
        crt_no_header_i = 1'b0;

        begin_test("tap");
        start_download(8'h81);
        for (int off = 0; off < TAP_BYTES; off++) begin
            byte_val = 8'($urandom);
            expect_write(1'b0, TAP_MEM_START + EXT_ADDR_W'(off), byte_val);
            send_byte(off, byte_val);
        end
        stop_download();
        check_value("tap_end_addr", 32'(TAP_MEM_START + EXT_ADDR_W'(TAP_BYTES - 1)),
                    32'(tap_end_addr_o));
        finish_test(0);

        begin_test("unknown");
        start_download(8'h02);
        for (int off = 0; off < NONE_BYTES; off++)
            send_byte(off, 8'($urandom));
        stop_download();
        finish_test(0);

        err_cnt = err_cnt + i_vic20_loader.i_sva.fail_cnt;
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb_clock.sv
/*
 * Testbench clock and reset
 * 100 MHz clk_sys, reset held high for the first ten cycles.
 */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_sys_o,
    output logic reset_o
);
    localparam int RESET_CYCLES = 10;

    // 10 ns period
    initial begin
        clk_sys_o = 1'b0;
        forever #5 clk_sys_o = ~clk_sys_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys_o);
        // Release away from the active edge
        @(negedge clk_sys_o);
        reset_o = 1'b0;
    end

endmodule

// File: vic20_loader_sva.sv
/*
 * Loader port assertions
 * Checks write port exclusivity, reset pulse width, quiet reset
 * and the legal internal address ranges at the top level.
 */
`timescale 1ns/1ps

module vic20_loader_sva (
    input logic                              clk_sys,
    input logic                              reset,
    input logic                              ext_we_i,
    input logic                              int_we_i,
    input logic [loader_pkg::CPU_ADDR_W-1:0] int_addr_i,
    input logic                              force_reset_i
);
    int fail_cnt = 0;

    // Zero page and low RAM, $1000 block, character ROM, colour RAM
    function automatic logic int_addr_ok(input logic [15:0] a);
        return (a < 16'h0400) ||
               (a >= 16'h1000 && a < 16'h2000) ||
               (a >= 16'h8000 && a < 16'h9000) ||
               (a >= 16'h9400 && a < 16'h9800);
    endfunction

    a_port_excl: assert property (@(posedge clk_sys) disable iff (reset)
        !(ext_we_i && int_we_i))
    else begin
        $error("external and internal write in the same cycle");
        fail_cnt++;
    end

    a_reset_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_i |=> !force_reset_i)
    else begin
        $error("force_reset held longer than one cycle");
        fail_cnt++;
    end

    // Outputs settle one edge after reset rises
    a_reset_quiet: assert property (@(posedge clk_sys)
        (reset && $past(reset)) |-> !(ext_we_i || int_we_i || force_reset_i))
    else begin
        $error("write or force_reset during reset");
        fail_cnt++;
    end

    a_int_range: assert property (@(posedge clk_sys) disable iff (reset)
        int_we_i |-> int_addr_ok(int_addr_i))
    else begin
        $error("internal write outside the allowed ranges");
        fail_cnt++;
    end

endmodule

bind vic20_loader vic20_loader_sva i_sva (
    .clk_sys       (clk_sys),
    .reset         (reset),
    .ext_we_i      (ext_we_o),
    .int_we_i      (int_we_o),
    .int_addr_i    (int_addr_o),
    .force_reset_i (force_reset_o)
);

// File: vic20_loader.sv
/*
 * VIC-20 image loader top level
 * Turns the host download stream into internal and external
 * memory writes, with BASIC pointer injection and auto reset.
 */
`timescale 1ns/1ps

module vic20_loader (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              dl_active_i,
    input  logic [7:0]                        dl_index_i,
    input  logic                              dl_wr_i,
    input  logic [loader_pkg::DL_ADDR_W-1:0]  dl_addr_i,
    input  logic [7:0]                        dl_data_i,
    input  logic                              crt_no_header_i,
    output logic                              ext_we_o,
    output logic [loader_pkg::EXT_ADDR_W-1:0] ext_addr_o,
    output logic [7:0]                        ext_data_o,
    output logic                              int_we_o,
    output logic [loader_pkg::CPU_ADDR_W-1:0] int_addr_o,
    output logic [7:0]                        int_data_o,
    output logic                              force_reset_o,
    output logic [loader_pkg::EXT_ADDR_W-1:0] tap_end_addr_o
);
    import loader_pkg::*;

    logic [CPU_ADDR_W-1:0] prg_end_addr;
    logic                  auto_reset;

    ioctl_if  dl_bus ();
    mem_wr_if rom_req ();
    mem_wr_if prg_req ();
    mem_wr_if inj_req ();

    // ==============================
    // Stream decode and requesters
    // ==============================
    load_decoder i_load_decoder (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .dl_active_i (dl_active_i),
        .dl_index_i  (dl_index_i),
        .dl_wr_i     (dl_wr_i),
        .dl_addr_i   (dl_addr_i),
        .dl_data_i   (dl_data_i),
        .dl          (dl_bus.source)
    );

    image_mapper i_image_mapper (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl             (dl_bus.sink),
        .req            (rom_req.requester),
        .tap_end_addr_o (tap_end_addr_o)
    );

    prg_loader i_prg_loader (
        .clk_sys         (clk_sys),
        .reset           (reset),
        .dl              (dl_bus.sink),
        .crt_no_header_i (crt_no_header_i),
        .req             (prg_req.requester),
        .end_addr_o      (prg_end_addr),
        .auto_reset_o    (auto_reset)
    );

    reg_injector i_reg_injector (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .prg_done_i    (dl_bus.prg_done),
        .end_addr_i    (prg_end_addr),
        .auto_reset_i  (auto_reset),
        .req           (inj_req.requester),
        .force_reset_o (force_reset_o)
    );

    // ==============================
    // Output ports
    // ==============================
    write_router i_write_router (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .rom_req    (rom_req.router),
        .prg_req    (prg_req.router),
        .inj_req    (inj_req.router),
        .ext_we_o   (ext_we_o),
        .ext_addr_o (ext_addr_o),
        .ext_data_o (ext_data_o),
        .int_we_o   (int_we_o),
        .int_addr_o (int_addr_o),
        .int_data_o (int_data_o)
    );

endmodule

// File: write_router.sv
/*
 * Write router
 * Merges the three write requests and drives either the external
 * memory port or the internal block RAM port, one cycle later.
 */
`timescale 1ns/1ps

module write_router (
    input  logic                              clk_sys,
    input  logic                              reset,
    mem_wr_if.router                          rom_req,
    mem_wr_if.router                          prg_req,
    mem_wr_if.router                          inj_req,
    output logic                              ext_we_o,
    output logic [loader_pkg::EXT_ADDR_W-1:0] ext_addr_o,
    output logic [7:0]                        ext_data_o,
    output logic                              int_we_o,
    output logic [loader_pkg::CPU_ADDR_W-1:0] int_addr_o,
    output logic [7:0]                        int_data_o
);
    import loader_pkg::*;

    logic                  any_we;
    logic                  any_int;
    logic [EXT_ADDR_W-1:0] any_addr;
    logic [7:0]            any_data;

    // Requesters are mutually exclusive, idle ones contribute zero
    always_comb begin
        any_we   = rom_req.we | prg_req.we | inj_req.we;
        any_int  = (rom_req.we & rom_req.internal) |
                   (prg_req.we & prg_req.internal) |
                   (inj_req.we & inj_req.internal);
        any_addr = ({EXT_ADDR_W{rom_req.we}} & rom_req.addr) |
                   ({EXT_ADDR_W{prg_req.we}} & prg_req.addr) |
                   ({EXT_ADDR_W{inj_req.we}} & inj_req.addr);
        any_data = ({8{rom_req.we}} & rom_req.data) |
                   ({8{prg_req.we}} & prg_req.data) |
                   ({8{inj_req.we}} & inj_req.data);
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            ext_we_o <= 1'b0;
            int_we_o <= 1'b0;
        end else begin
            ext_we_o <= any_we & ~any_int;
            int_we_o <= any_we & any_int;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (any_we && !any_int) begin
            ext_addr_o <= any_addr;
            ext_data_o <= any_data;
        end
        if (any_we && any_int) begin
            int_addr_o <= any_addr[CPU_ADDR_W-1:0];
            int_data_o <= any_data;
        end
    end

endmodule

// File: reg_injector.sv
/*
 * BASIC pointer injector
 * After a PRG load writes the end address into the eight BASIC
 * pointers, then pulses the core reset for cartridge images.
 */
`timescale 1ns/1ps

module reg_injector (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              prg_done_i,
    input  logic [loader_pkg::CPU_ADDR_W-1:0] end_addr_i,
    input  logic                              auto_reset_i,
    mem_wr_if.requester                       req,
    output logic                              force_reset_o
);
    import loader_pkg::*;

    localparam int IDX_W = $clog2(PTR_COUNT);

    inj_state_e       state;
    logic [IDX_W-1:0] ptr_idx;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state         <= INJ_IDLE;
            ptr_idx       <= '0;
            req.we        <= 1'b0;
            force_reset_o <= 1'b0;
        end else begin
            req.we        <= 1'b0;
            force_reset_o <= 1'b0;
            case (state)
                INJ_IDLE: begin
                    ptr_idx <= '0;
                    if (prg_done_i)
                        state <= INJ_WRITE;
                end
                INJ_WRITE: begin
                    req.we <= 1'b1;
                    state  <= INJ_GAP;
                end
                // Idle cycle between pointer writes
                INJ_GAP: begin
                    if (ptr_idx == IDX_W'(PTR_COUNT - 1)) begin
                        state <= INJ_RESET;
                    end else begin
                        ptr_idx <= ptr_idx + 1'b1;
                        state   <= INJ_WRITE;
                    end
                end
                INJ_RESET: begin
                    force_reset_o <= auto_reset_i;
                    state         <= INJ_IDLE;
                end
                default: state <= INJ_IDLE;
            endcase
        end
    end

    // Even entries take the low byte, odd entries the high byte
    always_ff @(posedge clk_sys) begin
        req.addr     <= EXT_ADDR_W'(PTR_ADDRS[ptr_idx]);
        req.data     <= ptr_idx[0] ? end_addr_i[15:8] : end_addr_i[7:0];
        req.internal <= 1'b1;
    end

endmodule

// File: prg_loader.sv
/*
 * PRG loader
 * Takes the load address from the header or the cartridge default,
 * writes payload bytes to consecutive addresses up to $BFFF.
 */
`timescale 1ns/1ps

module prg_loader (
    input  logic                              clk_sys,
    input  logic                              reset,
    ioctl_if.sink                             dl,
    input  logic                              crt_no_header_i,
    mem_wr_if.requester                       req,
    output logic [loader_pkg::CPU_ADDR_W-1:0] end_addr_o,
    output logic                              auto_reset_o
);
    import loader_pkg::*;

    logic [CPU_ADDR_W-1:0] next_addr;
    logic [CPU_ADDR_W-1:0] cur_addr;
    logic [CPU_ADDR_W-1:0] inc_addr;
    logic                  prg_wr;
    logic                  first_byte;
    logic                  second_byte;
    logic                  payload;

    assign prg_wr      = dl.wr & (dl.kind == LOAD_PRG);
    assign first_byte  = (dl.addr == '0);
    assign second_byte = (dl.addr == DL_ADDR_W'(1));

    // Header bytes carry no data to store
    assign payload = crt_no_header_i | ~(first_byte | second_byte);

    // Headerless image starts straight at the cartridge slot
    assign cur_addr = (crt_no_header_i && first_byte) ? PRG_CART_ADDR : next_addr;

    // Counter saturates so that ROM above $BFFF stays untouched
    assign inc_addr = (cur_addr == PRG_LIMIT) ? cur_addr : cur_addr + 1'b1;

    // RAM inside the core: low 1K, 4K block at $1000, colour RAM
    function automatic logic is_internal(input logic [CPU_ADDR_W-1:0] a);
        return (a[15:10] == 6'b000000) ||
               (a[15:12] == 4'b0001) ||
               (a[15:10] == 6'b100101);
    endfunction

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            next_addr    <= PRG_CART_ADDR;
            auto_reset_o <= 1'b0;
            req.we       <= 1'b0;
        end else begin
            req.we <= prg_wr & payload;
            if (prg_wr) begin
                if (crt_no_header_i) begin
                    next_addr <= inc_addr;
                    if (first_byte)
                        auto_reset_o <= 1'b1;
                end else if (first_byte) begin
                    next_addr[7:0] <= dl.data;
                    auto_reset_o   <= 1'b0;
                end else if (second_byte) begin
                    next_addr[15:8] <= dl.data;
                    auto_reset_o    <= ({dl.data, next_addr[7:0]} == PRG_CART_ADDR);
                end else begin
                    next_addr <= inc_addr;
                end
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        req.addr     <= EXT_ADDR_W'(cur_addr);
        req.data     <= dl.data;
        req.internal <= is_internal(cur_addr);
    end

    assign end_addr_o = next_addr;

endmodule

// File: image_mapper.sv
/*
 * ROM and tape image mapper
 * Places ROM bytes in kernal, BASIC and character areas and
 * TAP bytes in external memory, tracking the last TAP address.
 */
`timescale 1ns/1ps

module image_mapper (
    input  logic                              clk_sys,
    input  logic                              reset,
    ioctl_if.sink                             dl,
    mem_wr_if.requester                       req,
    output logic [loader_pkg::EXT_ADDR_W-1:0] tap_end_addr_o
);
    import loader_pkg::*;

    logic                  map_hit;
    logic                  map_int;
    logic [EXT_ADDR_W-1:0] map_addr;
    logic                  rom_low64k;

    // ROM images never exceed the first 64K of offsets
    assign rom_low64k = (dl.addr[DL_ADDR_W-1:16] == '0);

    always_comb begin
        map_hit  = 1'b0;
        map_int  = 1'b0;
        map_addr = '0;
        if (dl.kind == LOAD_ROM && rom_low64k) begin
            case (dl.addr[15:13])
                // Kernal PAL at $E000
                3'b010: begin
                    map_hit  = 1'b1;
                    map_addr = EXT_ADDR_W'({3'b111, dl.addr[12:0]});
                end
                // Kernal NTSC, same window in the upper bank
                3'b011: begin
                    map_hit  = 1'b1;
                    map_addr = EXT_ADDR_W'({3'b111, dl.addr[12:0]});
                    map_addr[NTSC_KERNAL_BIT] = 1'b1;
                end
                3'b100: begin
                    map_hit  = 1'b1;
                    map_addr = EXT_ADDR_W'({3'b110, dl.addr[12:0]});
                end
                // Character ROM sits in block RAM
                3'b101: begin
                    map_hit  = 1'b1;
                    map_int  = 1'b1;
                    map_addr = EXT_ADDR_W'({4'b1000, dl.addr[11:0]});
                end
                default: map_hit = 1'b0;
            endcase
        end else if (dl.kind == LOAD_TAP) begin
            map_hit  = 1'b1;
            map_addr = TAP_MEM_START + dl.addr[EXT_ADDR_W-1:0];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req.we         <= 1'b0;
            tap_end_addr_o <= TAP_MEM_START;
        end else begin
            req.we <= dl.wr & map_hit;
            if (dl.wr && dl.kind == LOAD_TAP)
                tap_end_addr_o <= map_addr;
        end
    end

    always_ff @(posedge clk_sys) begin
        req.addr     <= map_addr;
        req.data     <= dl.data;
        req.internal <= map_int;
    end

endmodule

// File: load_decoder.sv
/*
 * Download stream decoder
 * Registers the host stream, classifies the download index and
 * flags the end of a PRG download.
 */
`timescale 1ns/1ps

module load_decoder (
    input  logic                           clk_sys,
    input  logic                           reset,
    input  logic                           dl_active_i,
    input  logic [7:0]                     dl_index_i,
    input  logic                           dl_wr_i,
    input  logic [loader_pkg::DL_ADDR_W-1:0] dl_addr_i,
    input  logic [7:0]                     dl_data_i,
    ioctl_if.source                        dl
);
    import loader_pkg::*;

    load_kind_e index_kind;

    // Index decode, only valid while a download runs
    always_comb begin
        case (dl_index_i)
            8'h00:        index_kind = LOAD_ROM;
            8'h01, 8'h41: index_kind = LOAD_PRG;
            8'h81:        index_kind = LOAD_TAP;
            default:      index_kind = LOAD_NONE;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl.kind     <= LOAD_NONE;
            dl.wr       <= 1'b0;
            dl.prg_done <= 1'b0;
        end else begin
            dl.kind     <= dl_active_i ? index_kind : LOAD_NONE;
            dl.wr       <= dl_wr_i & dl_active_i;
            // Falling edge of an active PRG download
            dl.prg_done <= (dl.kind == LOAD_PRG) & ~dl_active_i;
        end
    end

    // Stream payload
    always_ff @(posedge clk_sys) begin
        dl.addr <= dl_addr_i;
        dl.data <= dl_data_i;
    end

endmodule

// File: loader_if.sv
/*
 * Loader interfaces
 * ioctl_if carries the registered host download stream,
 * mem_wr_if carries one memory write request to the router.
 */
`timescale 1ns/1ps

interface ioctl_if;
    import loader_pkg::*;

    load_kind_e           kind;
    logic                 wr;
    logic [DL_ADDR_W-1:0] addr;
    logic [7:0]           data;
    // End of a PRG download
    logic                 prg_done;

    modport source (
        output kind, wr, addr, data, prg_done
    );

    modport sink (
        input kind, wr, addr, data, prg_done
    );
endinterface

interface mem_wr_if;
    import loader_pkg::*;

    logic                  we;
    logic [EXT_ADDR_W-1:0] addr;
    logic [7:0]            data;
    // High for block RAM inside the emulator
    logic                  internal;

    modport requester (
        output we, addr, data, internal
    );

    modport router (
        input we, addr, data, internal
    );
endinterface

// File: loader_pkg.sv
/*
 * VIC-20 image loader shared definitions
 * Widths, fixed load addresses, BASIC pointer table and the
 * enumerations used by the decoder and the pointer injector.
 */
package loader_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int EXT_ADDR_W = 23;
    localparam int CPU_ADDR_W = 16;
    localparam int DL_ADDR_W  = 25;

    // ==============================
    // Fixed addresses
    // ==============================
    // Tape images live above the ROM area in external memory
    localparam logic [EXT_ADDR_W-1:0] TAP_MEM_START = 23'h020000;

    // Cartridge load address, also the auto-reset trigger
    localparam logic [CPU_ADDR_W-1:0] PRG_CART_ADDR = 16'hA000;
    localparam logic [CPU_ADDR_W-1:0] PRG_LIMIT     = 16'hBFFF;

    localparam int NTSC_KERNAL_BIT = 16;

    // BASIC zero-page pointers: TXTTAB end, VARTAB, ARYTAB, STREND and load end
    localparam int PTR_COUNT = 8;
    localparam logic [CPU_ADDR_W-1:0] PTR_ADDRS [PTR_COUNT] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

    // ==============================
    // Enumerations
    // ==============================
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_ROM,
        LOAD_PRG,
        LOAD_TAP
    } load_kind_e;

    typedef enum logic [1:0] {
        INJ_IDLE,
        INJ_WRITE,
        INJ_GAP,
        INJ_RESET
    } inj_state_e;

endpackage
